/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "Finished with no errors"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
rtl/rv_pkg.sv
rtl/instr_decoder.sv
rtl/int_regfile.sv
rtl/exec_unit.sv
rtl/core_control.sv
rtl/rv_core.sv
test/rv_core_assertions.sv
test/rv_core_tb.sv

/* rtl/core_control.sv */
`timescale 1ns/10ps
`default_nettype none

module core_control (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  rv_pkg::decoded_t             dec,
  input  rv_pkg::exec_result_t         res,
  input  wire logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::instr_t               instr,
  output logic [rv_pkg::xlen-1:0]      pc,
  output rv_pkg::reg_write_t           wr,
  output logic                         mem_valid,
  output logic                         mem_instr,
  input  wire logic                    mem_ready,
  output logic [rv_pkg::xlen-1:0]      mem_addr,
  output logic [rv_pkg::xlen-1:0]      mem_wdata,
  output logic [3:0]                   mem_wstrb,
  input  wire logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic                         trap
);
  import rv_pkg::*;

  logic [state_w-1:0] state;
  logic [xlen-1:0]    wb_data;
  logic [xlen-1:0]    pc_plus4;
  logic               uses_sum;
  logic               fault;

  assign pc_plus4 = pc + 32'd4;

  // sum is a pc target or a data address only for these
  assign uses_sum = dec.is_jal || dec.is_jalr || res.branch_taken || dec.is_load ||
                    dec.is_store;
  assign fault    = !dec.valid || (uses_sum && res.sum[1:0] != 2'b00);

  assign wr = '{en: (state == st_writeback), addr: dec.rd, data: wb_data};

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_fetch;
      pc        <= reset_vector;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= 4'b0000;
      trap      <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= 4'b0000;
          mem_addr  <= pc;
          state     <= st_wait_instr;
        end

        st_wait_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            instr     <= mem_rdata;
            state     <= st_execute;
          end
        end

        st_execute: begin
          if (fault) begin
            trap  <= 1'b1;
            state <= st_trapped;
          end else begin
            pc <= (dec.is_jal || dec.is_jalr || res.branch_taken) ? res.sum : pc_plus4;
            if (dec.is_branch) begin
              state <= st_fetch;
            end else if (dec.is_load || dec.is_store) begin
              mem_valid <= 1'b1;
              mem_instr <= 1'b0;
              mem_addr  <= res.sum;
              mem_wdata <= rs2_data;
              mem_wstrb <= dec.is_store ? 4'b1111 : 4'b0000;
              state     <= st_wait_mem;
            end else begin
              if (dec.is_jal || dec.is_jalr) begin
                wb_data <= pc_plus4;
              end else if (dec.is_auipc) begin
                wb_data <= res.sum;
              end else if (dec.is_alu || dec.is_lui) begin
                wb_data <= res.alu_result;
              end
              state <= st_writeback;
            end
          end
        end

        st_wait_mem: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= 4'b0000;
            if (dec.is_load) begin
              wb_data <= mem_rdata;
              state   <= st_writeback;
            end else begin
              state <= st_fetch;
            end
          end
        end

        st_writeback: state <= st_fetch;

        st_trapped: state <= st_trapped;

        default: begin
          trap  <= 1'b1;
          state <= st_trapped;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  input  rv_pkg::decoded_t            dec,
  input  wire logic [rv_pkg::xlen-1:0] pc,
  input  wire logic [rv_pkg::xlen-1:0] rs1_data,
  input  wire logic [rv_pkg::xlen-1:0] rs2_data,
  output rv_pkg::exec_result_t        res
);
  import rv_pkg::*;

  logic [xlen-1:0] operand_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] base;
  logic [xlen-1:0] raw_sum;
  logic            cond;

  assign operand_b = dec.use_imm ? dec.imm : rs2_data;
  assign shamt     = operand_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    res.alu_result = rs1_data + operand_b;
      alu_sub:    res.alu_result = rs1_data - operand_b;
      alu_sll:    res.alu_result = rs1_data << shamt;
      alu_slt:    res.alu_result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      alu_sltu:   res.alu_result = {31'b0, rs1_data < operand_b};
      alu_xor:    res.alu_result = rs1_data ^ operand_b;
      alu_srl:    res.alu_result = rs1_data >> shamt;
      alu_sra:    res.alu_result = $signed(rs1_data) >>> shamt;
      alu_or:     res.alu_result = rs1_data | operand_b;
      alu_and:    res.alu_result = rs1_data & operand_b;
      default:    res.alu_result = operand_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      f3_beq:  cond = rs1_data == rs2_data;
      f3_bne:  cond = rs1_data != rs2_data;
      f3_blt:  cond = $signed(rs1_data) < $signed(rs2_data);
      f3_bge:  cond = $signed(rs1_data) >= $signed(rs2_data);
      f3_bltu: cond = rs1_data < rs2_data;
      f3_bgeu: cond = rs1_data >= rs2_data;
      default: cond = 1'b0;
    endcase
  end

  assign res.branch_taken = dec.is_branch && cond;

  // register based for jalr and memory access, pc based otherwise
  assign base    = (dec.is_jalr || dec.is_load || dec.is_store) ? rs1_data : pc;
  assign raw_sum = base + dec.imm;
  assign res.sum = dec.is_jalr ? {raw_sum[xlen-1:1], 1'b0} : raw_sum;

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  rv_pkg::instr_t   instr,
  output rv_pkg::decoded_t dec
);
  import rv_pkg::*;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                f7_is_base;
  logic                f7_is_alt;
  logic                is_imm_form;
  logic [alu_op_w-1:0] alu_sel;
  logic                alu_legal;
  logic [xlen-1:0]     i_imm;
  logic [xlen-1:0]     s_imm;
  logic [xlen-1:0]     b_imm;
  logic [xlen-1:0]     u_imm;
  logic [xlen-1:0]     j_imm;

  assign opcode      = instr.r_fmt.opcode;
  assign funct3      = instr.r_fmt.funct3;
  assign funct7      = instr.r_fmt.funct7;
  assign f7_is_base  = funct7 == f7_base;
  assign f7_is_alt   = funct7 == f7_alt;
  assign is_imm_form = opcode == op_op_imm;

  assign i_imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
  assign s_imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
  assign b_imm = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                  instr.b_fmt.imm_4_1, 1'b0};
  assign u_imm = {instr.u_fmt.imm_31_12, 12'b0};
  assign j_imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                  instr.j_fmt.imm_10_1, 1'b0};

  // immediate forms carry imm[11:5] where funct7 sits, only shifts check it
  always_comb begin
    alu_sel   = alu_add;
    alu_legal = is_imm_form || f7_is_base;
    case (funct3)
      f3_add_sub: begin
        alu_sel   = (!is_imm_form && f7_is_alt) ? alu_sub : alu_add;
        alu_legal = is_imm_form || f7_is_base || f7_is_alt;
      end
      f3_sll: begin
        alu_sel   = alu_sll;
        alu_legal = f7_is_base;
      end
      f3_slt:  alu_sel = alu_slt;
      f3_sltu: alu_sel = alu_sltu;
      f3_xor:  alu_sel = alu_xor;
      f3_srl_sra: begin
        alu_sel   = f7_is_alt ? alu_sra : alu_srl;
        alu_legal = f7_is_base || f7_is_alt;
      end
      f3_or:   alu_sel = alu_or;
      default: alu_sel = alu_and;
    endcase
  end

  always_comb begin
    dec        = '0;
    dec.rd     = instr.r_fmt.rd;
    dec.rs1    = instr.r_fmt.rs1;
    dec.rs2    = instr.r_fmt.rs2;
    dec.funct3 = funct3;
    dec.alu_op = alu_sel;
    case (opcode)
      op_lui: begin
        dec.is_lui  = 1'b1;
        dec.valid   = 1'b1;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_b;
        dec.imm     = u_imm;
      end
      op_auipc: begin
        dec.is_auipc = 1'b1;
        dec.valid    = 1'b1;
        dec.imm      = u_imm;
      end
      op_jal: begin
        dec.is_jal = 1'b1;
        dec.valid  = 1'b1;
        dec.imm    = j_imm;
      end
      op_jalr: begin
        dec.is_jalr = 1'b1;
        dec.valid   = funct3 == 3'b000;
        dec.imm     = i_imm;
      end
      op_branch: begin
        dec.is_branch = 1'b1;
        dec.valid     = funct3 != 3'b010 && funct3 != 3'b011;
        dec.imm       = b_imm;
      end
      op_load: begin
        dec.is_load = 1'b1;
        dec.valid   = funct3 == f3_word;
        dec.imm     = i_imm;
      end
      op_store: begin
        dec.is_store = 1'b1;
        dec.valid    = funct3 == f3_word;
        dec.imm      = s_imm;
      end
      op_op_imm: begin
        dec.is_alu  = 1'b1;
        dec.valid   = alu_legal;
        dec.use_imm = 1'b1;
        dec.imm     = i_imm;
      end
      op_op: begin
        dec.is_alu = 1'b1;
        dec.valid  = alu_legal;
      end
      default: dec.valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/int_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module int_regfile (
  input  wire logic                          clk,
  input  wire logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  wire logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]            rs1_data,
  output logic [rv_pkg::xlen-1:0]            rs2_data,
  input  rv_pkg::reg_write_t                 wr
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [0:31];

  // x0 is never written, the read mux supplies its zero
  always_ff @(posedge clk) begin
    if (wr.en && wr.addr != '0) begin
      regs[wr.addr] <= wr.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  wire logic        clk,
  input  wire logic        reset,
  output logic             mem_valid,
  output logic             mem_instr,
  input  wire logic        mem_ready,
  output logic [31:0]      mem_addr,
  output logic [31:0]      mem_wdata,
  output logic [3:0]       mem_wstrb,
  input  wire logic [31:0] mem_rdata,
  output logic             trap
);
  import rv_pkg::*;

  instr_t          instr;
  decoded_t        dec;
  exec_result_t    res;
  reg_write_t      wr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  core_control control_i (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec),
    .res       (res),
    .rs2_data  (rs2_data),
    .instr     (instr),
    .pc        (pc),
    .wr        (wr),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  instr_decoder decoder_i (
    .instr (instr),
    .dec   (dec)
  );

  int_regfile regfile_i (
    .clk      (clk),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wr)
  );

  exec_unit exec_i (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .res      (res)
  );

endmodule

`default_nettype wire

/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam logic [xlen-1:0] reset_vector = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;

  // funct3 codes, branch conditions share the field with the ALU codes
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  localparam logic [2:0] f3_blt     = 3'b100;
  localparam logic [2:0] f3_bge     = 3'b101;
  localparam logic [2:0] f3_bltu    = 3'b110;
  localparam logic [2:0] f3_bgeu    = 3'b111;
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_word    = 3'b010;
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000;

  localparam int alu_op_w = 4;
  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // controller states
  localparam int state_w = 3;
  localparam logic [state_w-1:0] st_fetch      = 3'd0;
  localparam logic [state_w-1:0] st_wait_instr = 3'd1;
  localparam logic [state_w-1:0] st_execute    = 3'd2;
  localparam logic [state_w-1:0] st_wait_mem   = 3'd3;
  localparam logic [state_w-1:0] st_writeback  = 3'd4;
  localparam logic [state_w-1:0] st_trapped    = 3'd5;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  typedef struct packed {
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_branch;
    logic                  is_load;
    logic                  is_store;
    logic                  is_alu;
    logic                  valid;
    logic [alu_op_w-1:0]   alu_op;
    logic [2:0]            funct3;
    logic                  use_imm;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       imm;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] sum;
    logic            branch_taken;
  } exec_result_t;

  typedef struct packed {
    logic                  en;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } reg_write_t;

endpackage

`default_nettype wire

/* test/rv_core_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
  input wire logic        clk,
  input wire logic        reset,
  input wire logic        mem_valid,
  input wire logic        mem_instr,
  input wire logic        mem_ready,
  input wire logic [31:0] mem_addr,
  input wire logic [31:0] mem_wdata,
  input wire logic [3:0]  mem_wstrb,
  input wire logic        trap
);

  // a pending request holds until the memory takes it
  request_held: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_instr) &&
      $stable(mem_wstrb) && (mem_wstrb == 4'b0000 || $stable(mem_wdata)))
    else $error("memory request changed before mem_ready");

  trap_sticky: assert property (@(posedge clk) disable iff (reset) trap |=> trap)
    else $error("trap fell without a reset");

  no_request_in_trap: assert property (@(posedge clk) disable iff (reset) trap |-> !mem_valid)
    else $error("mem_valid high while trapped");

  fetch_never_writes: assert property (@(posedge clk) disable iff (reset)
    mem_instr |-> mem_wstrb == 4'b0000)
    else $error("write strobe set on an instruction fetch");

endmodule

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int mem_words    = 2048;
  localparam int data_base    = 32'h1000;
  localparam int data_words   = 64;
  localparam int prog_words   = 160;
  localparam int reset_cycles = 4;
  localparam int quiet_cycles = 24;

  typedef struct packed {
    logic            is_store;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } access_t;

  logic        clk;
  logic        reset;
  logic        mem_valid;
  logic        mem_instr;
  logic        mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        trap;

  int          seed;
  string       run_name;
  logic [31:0] bus_mem [0:mem_words-1];
  logic [31:0] model_mem [0:mem_words-1];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  access_t     expected_q [$];
  int          prog_count;
  logic [31:0] halt_addr;
  bit          halted;
  int          wait_left;
  int          trap_delay;

  rv_core dut_i (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  bind rv_core rv_core_assertions assertions_i (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .trap      (trap)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("CHECK FAILED [%s] %s: expected %h actual %h",
                              run_name, name, expected, actual));
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic logic [4:0] any_reg();
    return 5'(rand_below(16));
  endfunction

  // x20 holds the data base and x21 the jalr target so neither is a random destination
  function automatic logic [4:0] dest_reg();
    return 5'(rand_below(15) + 1);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic emit(input logic [31:0] word);
    model_mem[prog_count] = word;
    bus_mem[prog_count]   = word;
    prog_count++;
  endtask

  task automatic emit_alu();
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(rand_below(8));
    alt = (f3 == f3_add_sub || f3 == f3_srl_sra) && rand_below(2) == 1;
    if (rand_below(2) == 1) begin
      emit({alt ? f7_alt : f7_base, any_reg(), any_reg(), f3, dest_reg(), op_op});
    end else begin
      imm = 12'(rand_below(4096));
      if (f3 == f3_sll || f3 == f3_srl_sra) begin
        imm = {(f3 == f3_srl_sra && alt) ? f7_alt : f7_base, imm[4:0]};
      end
      emit(enc_i(imm, any_reg(), f3, dest_reg(), op_op_imm));
    end
  endtask

  // a taken skip jumps over k filler ops to the next group
  task automatic emit_branch_group();
    int         k;
    logic [2:0] f3;
    k  = rand_below(3) + 1;
    f3 = 3'(rand_below(6));
    if (f3 >= 3'd2) begin
      f3 = f3 + 3'd2;
    end
    emit(enc_b(13'((k + 1) * 4), any_reg(), any_reg(), f3));
    repeat (k) emit_alu();
  endtask

  task automatic emit_jal_group();
    int k;
    k = rand_below(3) + 1;
    emit(enc_j(21'((k + 1) * 4), any_reg()));
    repeat (k) emit_alu();
  endtask

  task automatic emit_jalr_group();
    int          k;
    logic [11:0] target;
    k      = rand_below(3) + 1;
    target = 12'((prog_count + 2 + k) * 4);
    emit(enc_i(target, 5'd0, 3'b000, 5'd21, op_op_imm));
    // the odd offset needs bit 0 of the target cleared
    emit(enc_i(12'd1, 5'd21, 3'b000, any_reg(), op_jalr));
    repeat (k) emit_alu();
  endtask

  task automatic emit_memory();
    logic [11:0] off;
    logic [4:0]  rd;
    off = 12'(rand_below(data_words) * 4);
    case (rand_below(3))
      0: emit(enc_s(off, any_reg(), 5'd20));
      1: emit(enc_i(off, 5'd20, f3_word, dest_reg(), op_load));
      default: begin
        // copy one data word to another slot
        rd = dest_reg();
        emit(enc_i(off, 5'd20, f3_word, rd, op_load));
        emit(enc_s(12'(rand_below(data_words) * 4), rd, 5'd20));
      end
    endcase
  endtask

  task automatic build_program(input bit bad_store);
    logic [31:0] addr;
    for (int i = 0; i < mem_words; i++) begin
      addr = 32'(i * 4);
      if (addr >= data_base && addr < data_base + data_words * 4) begin
        bus_mem[i] = fill_word(addr);
      end else begin
        bus_mem[i] = '0;
      end
      model_mem[i] = bus_mem[i];
    end
    prog_count = 0;
    emit(enc_u(20'(data_base >> 12), 5'd20, op_lui));
    for (int r = 1; r < 16; r++) begin
      emit(enc_i(12'(rand_below(4096)), 5'd0, 3'b000, 5'(r), op_op_imm));
    end
    while (prog_count < prog_words - 8) begin
      case (rand_below(9))
        0, 1, 2: emit_alu();
        3: emit(enc_u(20'(rand_below(1 << 20)), dest_reg(),
                      rand_below(2) == 1 ? op_lui : op_auipc));
        4: emit_branch_group();
        5: emit_jal_group();
        6: emit_jalr_group();
        default: emit_memory();
      endcase
    end
    halt_addr = 32'(prog_count * 4);
    if (bad_store) begin
      emit(enc_s(12'(rand_below(data_words) * 4 + rand_below(3) + 1), any_reg(), 5'd20));
    end
    emit(32'h0000_0000);
  endtask

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_step(output bit fault);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] next_pc;
    logic [31:0] addr;
    logic [31:0] result;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        wr_en;
    logic        taken;
    access_t     acc;

    ins     = model_mem[model_pc[12:2]];
    f3      = ins[14:12];
    rd      = ins[11:7];
    a       = model_regs[ins[19:15]];
    b       = model_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u   = {ins[31:12], 12'b0};
    imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = model_pc + 32'd4;
    result  = '0;
    addr    = '0;
    wr_en   = 1'b1;
    fault   = 1'b0;
    case (ins[6:0])
      op_lui:   result = imm_u;
      op_auipc: result = model_pc + imm_u;
      op_jal: begin
        result  = model_pc + 32'd4;
        next_pc = model_pc + imm_j;
      end
      op_jalr: begin
        result  = model_pc + 32'd4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      op_branch: begin
        wr_en = 1'b0;
        case (f3)
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) begin
          next_pc = model_pc + imm_b;
        end
      end
      op_op_imm: result = alu_model(f3, ins[30] && f3 == 3'd5, a, imm_i);
      op_op:     result = alu_model(f3, ins[30], a, b);
      op_load: begin
        addr   = a + imm_i;
        fault  = addr[1:0] != 2'b00;
        result = model_mem[addr[12:2]];
        acc    = {1'b0, addr, result};
      end
      op_store: begin
        wr_en = 1'b0;
        addr  = a + imm_s;
        fault = addr[1:0] != 2'b00;
        acc   = {1'b1, addr, b};
      end
      default: fault = 1'b1;
    endcase
    if (next_pc[1:0] != 2'b00) begin
      fault = 1'b1;
    end
    if (!fault) begin
      if (ins[6:0] == op_load || ins[6:0] == op_store) begin
        expected_q.push_back(acc);
      end
      if (ins[6:0] == op_store) begin
        model_mem[addr[12:2]] = b;
      end
      if (wr_en && rd != 5'd0) begin
        model_regs[rd] = result;
      end
      model_pc = next_pc;
    end
  endtask

  task automatic complete_transfer();
    access_t exp;
    bit      fault;
    if (mem_instr) begin
      check_value("fetch address", model_pc, mem_addr);
      check_value("fetch write strobe", 32'd0, 32'(mem_wstrb));
      check_value("trap before fetch", 32'd0, 32'(trap));
      check_value("data accesses left over", 32'd0, 32'(expected_q.size()));
      model_step(fault);
      halted = fault;
    end else if (expected_q.size() == 0) begin
      stop_on_error($sformatf("[%s] data access at %h that the program does not make",
                              run_name, mem_addr));
    end else begin
      exp = expected_q.pop_front();
      check_value("data access kind", 32'(exp.is_store), 32'(mem_wstrb != 4'b0000));
      check_value("data address", exp.addr, mem_addr);
      if (exp.is_store) begin
        check_value("store write strobe", 32'hf, 32'(mem_wstrb));
        check_value("store data", exp.data, mem_wdata);
        bus_mem[mem_addr[12:2]] = mem_wdata;
      end
    end
  endtask

  // memory model with a random wait before each acknowledge
  always @(posedge clk) begin
    if (reset) begin
      mem_ready  <= 1'b0;
      wait_left  <= 0;
      trap_delay <= 0;
    end else if (halted && mem_valid) begin
      stop_on_error($sformatf("[%s] memory request raised after the faulting word at %h",
                              run_name, halt_addr));
    end else if (mem_valid && mem_ready) begin
      complete_transfer();
      mem_ready <= 1'b0;
      wait_left <= rand_below(4);
    end else if (mem_valid) begin
      if (wait_left == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= bus_mem[mem_addr[12:2]];
      end else begin
        wait_left <= wait_left - 1;
      end
    end else if (halted && !trap) begin
      // cycles between the faulting fetch and trap
      trap_delay <= trap_delay + 1;
    end
  end

  task automatic run_program(input string name, input bit bad_store);
    int limit;
    int cycles;
    run_name = name;
    @(posedge clk);
    reset <= 1'b1;
    build_program(bad_store);
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    model_pc = reset_vector;
    expected_q.delete();
    halted = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    limit  = prog_count * 12 + reset_cycles;
    cycles = 0;
    while (!(halted && trap)) begin
      @(posedge clk);
      cycles++;
      if (trap && !halted) begin
        stop_on_error($sformatf("[%s] trap raised at %h where the program has no fault",
                                name, model_pc));
      end else if (cycles > limit) begin
        stop_on_error($sformatf("[%s] timeout, trap not raised within %0d cycles",
                                name, limit));
      end
    end
    // execute follows the fetch edge and trap follows execute
    check_value("cycles from faulting fetch to trap", 32'd1, 32'(trap_delay));
    repeat (quiet_cycles) begin
      @(posedge clk);
      check_value("trap held", 32'd1, 32'(trap));
    end
  endtask

  initial begin
    seed      = 93845;
    clk       = 1'b0;
    reset     = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    wait_left = 0;
    halted    = 1'b0;
    run_program("random program", 1'b0);
    run_program("misaligned store", 1'b1);
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
